// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= zxuno_io_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+1000

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM) $(RUN_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "tests failed" $(LOG); then exit 1; fi; exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== filelist.f ====
verilog/zxuno_bus_pkg.sv
verilog/zxuno_cfg_pkg.sv
verilog/zxreg_if.sv
verilog/zxuno_regport.sv
verilog/option_regs.sv
verilog/coreid_reader.sv
verilog/cpu_din_mux.sv
verilog/zxuno_io.sv
verification/zxuno_io_asserts.sv
verification/tb_clkgen.sv
verification/zxuno_io_tb.sv

// ==== verification/tb_clkgen.sv ====
`timescale 1ns/1ps

module tb_clkgen (
  input  logic rst_req,
  output logic clk,
  output logic rst_n
);

  localparam int PERIOD_NS  = 100;
  localparam int RST_CYCLES = 3;

  logic        rst_q = 1'b0;
  int unsigned rst_cnt = RST_CYCLES - 1;

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Low for three edges at start, and again on request
  always @(posedge clk) begin
    if (rst_req) begin
      rst_q   <= 1'b0;
      rst_cnt <= RST_CYCLES - 1;
    end else if (rst_cnt != 0) begin
      rst_cnt <= rst_cnt - 1;
    end else begin
      rst_q <= 1'b1;
    end
  end

  assign rst_n = rst_q;

endmodule

// ==== verification/zxuno_io_asserts.sv ====
`timescale 1ns/1ps

module zxuno_io_asserts (
  input logic        clk,
  input logic        rst_n,
  input logic [15:0] a,
  input logic        iorq_n,
  input logic        rd_n,
  input logic        regrd,
  input logic        regwr,
  input logic        opt_oe
);

  // Read by the testbench summary
  int unsigned fail_cnt = 0;

  // Data port is either read or written, never both
  rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n) !(regrd && regwr))
    else begin
      fail_cnt++;
      $error("regrd and regwr high in the same cycle");
    end

  // One write strobe per access
  wr_single: assert property (@(posedge clk) disable iff (!rst_n) regwr |=> !regwr)
    else begin
      fail_cnt++;
      $error("regwr high for two cycles");
    end

  // Option readback only while the CPU reads the data port
  opt_oe_rd: assert property (@(posedge clk) disable iff (!rst_n)
    opt_oe |-> (!iorq_n && !rd_n && a == zxuno_bus_pkg::DATA_PORT))
    else begin
      fail_cnt++;
      $error("option block drives the bus outside a data port read");
    end

endmodule

bind zxuno_io zxuno_io_asserts bus_checks (
  .clk    (clk           ),
  .rst_n  (rst_n         ),
  .a      (a             ),
  .iorq_n (iorq_n        ),
  .rd_n   (rd_n          ),
  .regrd  (reg_bus.regrd ),
  .regwr  (reg_bus.regwr ),
  .opt_oe (opt_rd.oe     )
);

// ==== verification/zxuno_io_patterns.txt ====
# op addr data expected; W write, R read and compare, A interrupt acknowledge, X reset
# values are hex, expected is ignored for W and X
R FC3B 00 00
W FC3B 0E 00
R FC3B 00 0E
W FD3B A5 00
R FD3B 00 A5
W FC3B 03 00
W FD3B 5C 00
R FD3B 00 5C
W FC3B 0E 00
R FD3B 00 A5
W FC3B FF 00
R FD3B 00 45
R FD3B 00 58
R FD3B 00 50
R FD3B 00 32
R FD3B 00 36
R FD3B 00 41
R FD3B 00 00
R FD3B 00 45
W FC3B FF 00
R FD3B 00 45
A FD3B 00 FF
A FC3B 00 FF
R 1234 00 FF
W FC3B 42 00
R FD3B 00 FF
X 0000 00 00
R FC3B 00 00
W FC3B 03 00
R FD3B 00 00
W FC3B 0E 00
R FD3B 00 00

// ==== verification/zxuno_io_tb.sv ====
`timescale 1ns/1ps

module zxuno_io_tb;

  localparam string       PATTERN_FILE = "verification/zxuno_io_patterns.txt";
  localparam int unsigned SEED         = 74619;
  // Three busy cycles plus up to four idle ones, with room to spare
  localparam int          CYCLES_PER_OP = 8;
  localparam int          SLACK_CYCLES  = 20;

  logic                    clk;
  logic                    rst_n;
  logic                    rst_req;
  logic [15:0]             a;
  logic                    iorq_n;
  logic                    rd_n;
  logic                    wr_n;
  logic                    m1_n;
  logic [7:0]              din;
  logic [7:0]              cpu_din;
  zxuno_cfg_pkg::devopts_t dev_options;

  // Pattern table, one entry per line of the file
  logic [7:0]  op_q[$];
  logic [15:0] addr_q[$];
  logic [7:0]  data_q[$];
  logic [7:0]  exp_q[$];

  int n_ops = 0;
  int checks = 0;
  int errors = 0;

  tb_clkgen clkgen (
    .rst_req (rst_req),
    .clk     (clk    ),
    .rst_n   (rst_n  ));

  zxuno_io UUT (
    .clk         (clk        ),
    .rst_n       (rst_n      ),
    .a           (a          ),
    .iorq_n      (iorq_n     ),
    .rd_n        (rd_n       ),
    .wr_n        (wr_n       ),
    .m1_n        (m1_n       ),
    .din         (din        ),
    .cpu_din     (cpu_din    ),
    .dev_options (dev_options));

  // ------------------------------------------------------------------------
  // Compare tasks
  // ------------------------------------------------------------------------

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] t=%0t %s expected %02h actual %02h", $time, name, exp, act);
    end
  endtask

  task automatic check_opts(input zxuno_cfg_pkg::devopts_t exp,
                            input zxuno_cfg_pkg::devopts_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] t=%0t dev_options expected %02h actual %02h", $time, exp, act);
    end
  endtask

  task automatic load_patterns();
    int          fd;
    int          n;
    string       line;
    logic [7:0]  op;
    logic [15:0] addr;
    logic [7:0]  data;
    logic [7:0]  exp;
    fd = $fopen(PATTERN_FILE, "r");
    if (fd == 0) begin
      errors++;
      $display("Cannot open the pattern file %s", PATTERN_FILE);
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%c %h %h %h", op, addr, data, exp);
        if (n == 4) begin
          op_q.push_back(op);
          addr_q.push_back(addr);
          data_q.push_back(data);
          exp_q.push_back(exp);
        end
      end
    end
    $fclose(fd);
  endtask

  // One bus access, three cycles held, then idle
  task automatic do_access(
    input  logic [7:0]              op,
    input  logic [15:0]             addr,
    input  logic [7:0]              data,
    output logic [7:0]              got,
    output zxuno_cfg_pkg::devopts_t opts_got
  );
    int unsigned extra;
    @(posedge clk);
    a      <= addr;
    din    <= data;
    iorq_n <= 1'b0;
    // Acknowledge is held as a read too, so a selected source also answers
    rd_n   <= (op != "R") && (op != "A");
    wr_n   <= (op != "W");
    m1_n   <= (op != "A");
    repeat (2) @(posedge clk);
    // Middle of the third cycle
    @(negedge clk);
    got      = cpu_din;
    opts_got = dev_options;
    @(posedge clk);
    iorq_n <= 1'b1;
    rd_n   <= 1'b1;
    wr_n   <= 1'b1;
    m1_n   <= 1'b1;
    extra = $urandom % 4;
    repeat (extra) @(posedge clk);
  endtask

  task automatic pulse_reset();
    @(posedge clk);
    rst_req <= 1'b1;
    @(posedge clk);
    rst_req <= 1'b0;
    @(negedge clk);
    wait (rst_n === 1'b1);
  endtask

  // ------------------------------------------------------------------------
  // Pattern run
  // ------------------------------------------------------------------------

  initial begin
    logic [7:0]              got;
    logic [7:0]              sel_model;
    zxuno_cfg_pkg::devopts_t opts_got;
    zxuno_cfg_pkg::devopts_t opts_model;
    int                      errs_before;
    void'($urandom(SEED));
    rst_req <= 1'b0;
    a       <= 16'h0000;
    din     <= 8'h00;
    iorq_n  <= 1'b1;
    rd_n    <= 1'b1;
    wr_n    <= 1'b1;
    m1_n    <= 1'b1;
    sel_model  = 8'h00;
    opts_model = '0;
    load_patterns();
    n_ops = op_q.size();
    wait (rst_n === 1'b1);
    for (int i = 0; i < n_ops; i++) begin
      errs_before = errors;
      if (op_q[i] == "X") begin
        pulse_reset();
        sel_model  = 8'h00;
        opts_model = '0;
        check_opts(opts_model, dev_options);
      end else begin
        do_access(op_q[i], addr_q[i], data_q[i], got, opts_got);
        if (op_q[i] == "W" && addr_q[i] == zxuno_bus_pkg::ADDR_PORT) begin
          sel_model = data_q[i];
        end
        if (op_q[i] == "W" && addr_q[i] == zxuno_bus_pkg::DATA_PORT &&
            sel_model == zxuno_bus_pkg::REG_DEVOPTS) begin
          opts_model = zxuno_cfg_pkg::devopts_t'(data_q[i]);
        end
        if (op_q[i] != "W") begin
          check_byte("cpu_din", exp_q[i], got);
        end
        check_opts(opts_model, opts_got);
      end
      $display("Test %0d: %c %04h %02h %s", i + 1, op_q[i], addr_q[i], data_q[i],
               (errors == errs_before) ? "ok" : "mismatch");
    end
    if (n_ops == 0) begin
      errors++;
      $display("No patterns were loaded");
    end
    errors += int'(UUT.bus_checks.fail_cnt);
    $display("Summary: %0d checks, %0d errors, %0d assertion failures",
             checks, errors, UUT.bus_checks.fail_cnt);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Watchdog sized from the pattern count
  initial begin
    wait (n_ops > 0);
    repeat (n_ops * CYCLES_PER_OP + SLACK_CYCLES) @(posedge clk);
    $display("Timeout: the pattern run did not finish in %0d cycles",
             n_ops * CYCLES_PER_OP + SLACK_CYCLES);
    $display("tests failed");
    $finish;
  end

endmodule

// ==== verilog/coreid_reader.sv ====
`timescale 1ns/1ps

module coreid_reader (
  input  logic                       clk,
  input  logic                       rst_n,
  zxreg_if.dev                       reg_bus,
  output zxuno_bus_pkg::rd_result_t  rd
);

  // One extra slot for the terminator
  typedef logic [$clog2(zxuno_cfg_pkg::COREID_LEN+1)-1:0] idx_t;

  typedef enum logic {
    ID_IDLE,
    ID_READING
  } id_state_e;

  id_state_e  state;
  idx_t       idx;
  logic       reading;
  logic [7:0] chr;

  assign reading = reg_bus.regrd && (reg_bus.addr == zxuno_bus_pkg::REG_COREID);

  // ------------------------------------------------------------------------
  // Index moves once per read, after the read ends
  // ------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ID_IDLE;
      idx   <= '0;
    end else if (reg_bus.regaddr_changed) begin
      // New register selected, restart the string
      state <= ID_IDLE;
      idx   <= '0;
    end else begin
      case (state)
        ID_IDLE: begin
          if (reading) begin
            state <= ID_READING;
          end
        end
        ID_READING: begin
          if (!reading) begin
            state <= ID_IDLE;
            if (idx == idx_t'(zxuno_cfg_pkg::COREID_LEN)) begin
              idx <= '0;
            end else begin
              idx <= idx + idx_t'(1);
            end
          end
        end
        default: state <= ID_IDLE;
      endcase
    end
  end

  // Character select, 0x00 past the end
  always_comb begin
    chr = 8'h00;
    for (int i = 0; i < zxuno_cfg_pkg::COREID_LEN; i++) begin
      if (idx == idx_t'(i)) begin
        chr = zxuno_cfg_pkg::COREID_STR[8*(zxuno_cfg_pkg::COREID_LEN-1-i) +: 8];
      end
    end
  end

  always_comb begin
    rd.data = chr;
    rd.oe   = reading;
  end

endmodule

// ==== verilog/cpu_din_mux.sv ====
`timescale 1ns/1ps

module cpu_din_mux (
  input  logic                       iorq_n,
  input  logic                       m1_n,
  input  zxuno_bus_pkg::rd_result_t  port_rd,
  input  zxuno_bus_pkg::rd_result_t  opt_rd,
  input  zxuno_bus_pkg::rd_result_t  id_rd,
  output logic [7:0]                 cpu_din
);

  logic int_ack;

  // Z80 interrupt acknowledge cycle
  assign int_ack = !iorq_n && !m1_n;

  // First match wins
  always_comb begin
    case (1'b1)
      int_ack    : cpu_din = zxuno_bus_pkg::IDLE_BYTE;
      port_rd.oe : cpu_din = port_rd.data;
      id_rd.oe   : cpu_din = id_rd.data;
      opt_rd.oe  : cpu_din = opt_rd.data;
      // Nobody drives the bus
      default    : cpu_din = zxuno_bus_pkg::IDLE_BYTE;
    endcase
  end

endmodule

// ==== verilog/option_regs.sv ====
`timescale 1ns/1ps

module option_regs (
  input  logic                       clk,
  input  logic                       rst_n,
  zxreg_if.dev                       reg_bus,
  output zxuno_cfg_pkg::devopts_t    dev_options,
  output zxuno_bus_pkg::rd_result_t  rd
);

  zxuno_cfg_pkg::devopts_t devopts_q;
  logic [7:0]              scratch_q;
  logic                    opts_sel;
  logic                    scratch_sel;

  assign opts_sel    = (reg_bus.addr == zxuno_bus_pkg::REG_DEVOPTS);
  assign scratch_sel = (reg_bus.addr == zxuno_bus_pkg::REG_SCRATCH);

  // Both registers share the write strobe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      devopts_q <= '0;
      scratch_q <= 8'h00;
    end else if (reg_bus.regwr) begin
      if (opts_sel) begin
        devopts_q <= zxuno_cfg_pkg::devopts_t'(reg_bus.wdata);
      end
      if (scratch_sel) begin
        scratch_q <= reg_bus.wdata;
      end
    end
  end

  // Enables go straight to the devices
  assign dev_options = devopts_q;

  // Readback while the data port is being read
  always_comb begin
    rd.data = scratch_q;
    if (opts_sel) begin
      rd.data = devopts_q;
    end
    rd.oe = reg_bus.regrd && (opts_sel || scratch_sel);
  end

endmodule

// ==== verilog/zxreg_if.sv ====
`timescale 1ns/1ps

// Register window between the port decoder and the register blocks
interface zxreg_if;

  // Currently selected register number
  zxuno_bus_pkg::zxreg_e addr;
  // Data port read in progress, a level
  logic       regrd;
  // Data port write, one cycle per access
  logic       regwr;
  // Address port written, one cycle per access
  logic       regaddr_changed;
  logic [7:0] wdata;

  modport port (
    output addr, regrd, regwr, regaddr_changed, wdata
  );

  modport dev (
    input addr, regrd, regwr, regaddr_changed, wdata
  );

endinterface

// ==== verilog/zxuno_bus_pkg.sv ====
package zxuno_bus_pkg;

  // ------------------------------------------------------------------------
  // CPU side I/O ports of the register window
  // ------------------------------------------------------------------------

  // Register number goes here
  localparam logic [15:0] ADDR_PORT = 16'hFC3B;
  // Register contents go here
  localparam logic [15:0] DATA_PORT = 16'hFD3B;

  // Floating bus value, also the byte put on the bus for INT acknowledge
  localparam logic [7:0] IDLE_BYTE = 8'hFF;

  // Register numbers behind the data port
  typedef enum logic [7:0] {
    REG_SCRATCH = 8'h03,
    REG_DEVOPTS = 8'h0E,
    REG_COREID  = 8'hFF
  } zxreg_e;

  // Answer of a bus source to a CPU read
  typedef struct packed {
    logic [7:0] data;
    logic       oe;
  } rd_result_t;

endpackage

// ==== verilog/zxuno_cfg_pkg.sv ====
package zxuno_cfg_pkg;

  // ------------------------------------------------------------------------
  // Device enable register, number 0x0E
  // ------------------------------------------------------------------------

  // Bit 7 first
  typedef struct packed {
    logic disable_spisd;
    logic enable_timexmmu;
    logic disable_romsel1f;
    logic disable_romsel7f;
    logic disable_1ffd;
    logic disable_7ffd;
    logic disable_turboay;
    logic disable_ay;
  } devopts_t;

  // ------------------------------------------------------------------------
  // Core identification
  // ------------------------------------------------------------------------

  // Characters in the string, not counting the 0x00 terminator
  localparam int COREID_LEN = 6;

  // First character sits in the top byte
  localparam logic [8*COREID_LEN-1:0] COREID_STR = "EXP26A";

endpackage

// ==== verilog/zxuno_io.sv ====
`timescale 1ns/1ps

module zxuno_io (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [15:0]              a,
  input  logic                     iorq_n,
  input  logic                     rd_n,
  input  logic                     wr_n,
  input  logic                     m1_n,
  input  logic [7:0]               din,
  output logic [7:0]               cpu_din,
  output zxuno_cfg_pkg::devopts_t  dev_options
);

  // Read answers towards the data-in mux
  zxuno_bus_pkg::rd_result_t port_rd;
  zxuno_bus_pkg::rd_result_t opt_rd;
  zxuno_bus_pkg::rd_result_t id_rd;

  zxreg_if reg_bus ();

  // ------------------------------------------------------------------------
  // Port decoder and register blocks
  // ------------------------------------------------------------------------

  zxuno_regport regport (
    .clk         (clk           ),
    .rst_n       (rst_n         ),
    .a           (a             ),
    .iorq_n      (iorq_n        ),
    .rd_n        (rd_n          ),
    .wr_n        (wr_n          ),
    .din         (din           ),
    .reg_bus     (reg_bus.port  ),
    .rd          (port_rd       ));

  option_regs device_options (
    .clk         (clk           ),
    .rst_n       (rst_n         ),
    .reg_bus     (reg_bus.dev   ),
    .dev_options (dev_options   ),
    .rd          (opt_rd        ));

  coreid_reader core_id (
    .clk         (clk           ),
    .rst_n       (rst_n         ),
    .reg_bus     (reg_bus.dev   ),
    .rd          (id_rd         ));

  // Byte returned to the CPU
  cpu_din_mux din_mux (
    .iorq_n      (iorq_n        ),
    .m1_n        (m1_n          ),
    .port_rd     (port_rd       ),
    .opt_rd      (opt_rd        ),
    .id_rd       (id_rd         ),
    .cpu_din     (cpu_din       ));

endmodule

// ==== verilog/zxuno_regport.sv ====
`timescale 1ns/1ps

module zxuno_regport (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [15:0]                a,
  input  logic                       iorq_n,
  input  logic                       rd_n,
  input  logic                       wr_n,
  input  logic [7:0]                 din,
  zxreg_if.port                      reg_bus,
  output zxuno_bus_pkg::rd_result_t  rd
);

  logic addr_sel;
  logic data_sel;
  logic rd_access;
  logic wr_access;
  logic wr_seen;
  logic wr_first;
  logic regwr_q;
  logic changed_q;
  zxuno_bus_pkg::zxreg_e addr_q;

  // Full 16 bit decode of both ports
  assign addr_sel = (a == zxuno_bus_pkg::ADDR_PORT);
  assign data_sel = (a == zxuno_bus_pkg::DATA_PORT);

  assign rd_access = !iorq_n && !rd_n;
  assign wr_access = !iorq_n && !wr_n;

  // First cycle of a write access only
  assign wr_first = wr_access && !wr_seen;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_seen   <= 1'b0;
      regwr_q   <= 1'b0;
      changed_q <= 1'b0;
      addr_q    <= zxuno_bus_pkg::zxreg_e'(8'h00);
    end else begin
      wr_seen   <= wr_access;
      regwr_q   <= wr_first && data_sel;
      changed_q <= wr_first && addr_sel;
      // Any byte is accepted here, unused numbers just read as idle
      if (wr_first && addr_sel) begin
        addr_q <= zxuno_bus_pkg::zxreg_e'(din);
      end
    end
  end

  // ------------------------------------------------------------------------
  // Register window outputs
  // ------------------------------------------------------------------------

  assign reg_bus.addr            = addr_q;
  assign reg_bus.regrd           = data_sel && rd_access;
  assign reg_bus.regwr           = regwr_q;
  assign reg_bus.regaddr_changed = changed_q;
  assign reg_bus.wdata           = din;

  // Address port readback
  always_comb begin
    rd.data = addr_q;
    rd.oe   = addr_sel && rd_access;
  end

endmodule
